// ==== logic/ntm_pkg.sv ====
////////////////////////////////////////////////////////////
// NTM trainer shared definitions
// Word width, size bounds, counter widths and FSM codes
////////////////////////////////////////////////////////////
package ntm_pkg;

  // Every data word wraps modulo 2^16
  localparam int DATA_SIZE = 16;

  // Largest hidden and input vector lengths
  localparam int MAX_L = 4;
  localparam int MAX_X = 4;

  // Element index, size input and step count widths
  localparam int INDEX_SIZE = 2;
  localparam int COUNT_SIZE = 3;
  localparam int STEP_SIZE  = 8;

  // Pipeline stages from last x strobe to first W word
  localparam int DRAIN_CYCLES = 3;
  localparam int DRAIN_SIZE   = 2;

  // Trainer FSM encoding
  localparam int STATE_SIZE = 3;

  localparam logic [STATE_SIZE-1:0] IDLE_STATE  = 3'd0;
  localparam logic [STATE_SIZE-1:0] INPUT_STATE = 3'd1;
  localparam logic [STATE_SIZE-1:0] DRAIN_STATE = 3'd2;
  localparam logic [STATE_SIZE-1:0] W_STATE     = 3'd3;
  localparam logic [STATE_SIZE-1:0] B_STATE     = 3'd4;
  localparam logic [STATE_SIZE-1:0] READY_STATE = 3'd5;

endpackage

// ==== logic/ntm_vector_differentiation.sv ====
////////////////////////////////////////////////////////////
// NTM vector differentiation
// Time difference d(t;l) = h(t;l) - h(t-1;l), h(-1) = 0
////////////////////////////////////////////////////////////
module ntm_vector_differentiation (
  input  logic                           CLK,
  input  logic                           RST,

  // Run start, empties the previous-step vector
  input  logic                           clear,

  // Hidden vector element from the host
  input  logic                           h_valid,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] h_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  h_data,

  // Difference element, one cycle later
  output logic                           diff_valid,
  output logic [ntm_pkg::INDEX_SIZE-1:0] diff_index,
  output logic [ntm_pkg::DATA_SIZE-1:0]  diff_data
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // h(t-1), one word per hidden element
  logic [DATA_SIZE-1:0] prev_h [MAX_L];

  ////////////////////////////////////////////////////////////
  // Difference stage
  ////////////////////////////////////////////////////////////

  // Valid flag follows the strobe by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      diff_valid <= 1'b0;
    end else begin
      diff_valid <= h_valid;
    end
  end

  // Difference word and its tag
  // Subtraction wraps mod 2^16 by width
  always_ff @(posedge CLK) begin
    if (h_valid) begin
      diff_index <= h_index;
      diff_data  <= h_data - prev_h[h_index];
    end
  end

  // Previous-step vector
  // Zeroed at run start so step 0 gives d = h
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < MAX_L; l++) begin
        prev_h[l] <= '0;
      end
    end else if (clear) begin
      for (int l = 0; l < MAX_L; l++) begin
        prev_h[l] <= '0;
      end
    end else if (h_valid) begin
      // Current word becomes h(t-1) for the next step
      prev_h[h_index] <= h_data;
    end
  end

endmodule

// ==== logic/ntm_matrix_product.sv ====
////////////////////////////////////////////////////////////
// NTM matrix product
// Outer product d(t)·x(t), one column per input element
////////////////////////////////////////////////////////////
module ntm_matrix_product (
  input  logic                           CLK,
  input  logic                           RST,

  // Difference element from the differentiation stage
  input  logic                           diff_valid,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] diff_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  diff_data,

  // Input vector element from the host
  input  logic                           x_valid,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] x_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  x_data,

  // Product column for input element prod_index
  output logic                           prod_valid,
  output logic [ntm_pkg::INDEX_SIZE-1:0] prod_index,
  output logic [ntm_pkg::DATA_SIZE-1:0]  prod_column [ntm_pkg::MAX_L]
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Difference vector
  ////////////////////////////////////////////////////////////

  // d(t), filled element by element
  logic [DATA_SIZE-1:0] d_reg [MAX_L];

  // d(t) as seen by the multipliers this cycle
  logic [DATA_SIZE-1:0] d_cur [MAX_L];

  always_ff @(posedge CLK) begin
    if (diff_valid) begin
      d_reg[diff_index] <= diff_data;
    end
  end

  // Forward the element still in flight
  // The first x strobe may meet the last difference of the step
  always_comb begin
    for (int l = 0; l < MAX_L; l++) begin
      if (diff_valid && (diff_index == INDEX_SIZE'(l))) begin
        d_cur[l] = diff_data;
      end else begin
        d_cur[l] = d_reg[l];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Product column
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= x_valid;
    end
  end

  // One multiplier per row
  // Rows at or above L carry stale values and are never read out
  always_ff @(posedge CLK) begin
    if (x_valid) begin
      prod_index <= x_index;
      for (int l = 0; l < MAX_L; l++) begin
        // 16-bit context keeps the low half of the product
        prod_column[l] <= d_cur[l] * x_data;
      end
    end
  end

endmodule

// ==== logic/ntm_vector_summation.sv ====
////////////////////////////////////////////////////////////
// NTM vector summation
// Accumulates dW and db over time, read back by index
////////////////////////////////////////////////////////////
module ntm_vector_summation (
  input  logic                           CLK,
  input  logic                           RST,

  // Run start, empties both accumulator arrays
  input  logic                           clear,

  // Difference element, adds into db
  input  logic                           diff_valid,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] diff_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  diff_data,

  // Product column, adds into one column of dW
  input  logic                           prod_valid,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] prod_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  prod_column [ntm_pkg::MAX_L],

  // Read-back selection
  input  logic [ntm_pkg::INDEX_SIZE-1:0] read_l,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] read_x,

  // Selected dW(l,x) and db(l)
  output logic [ntm_pkg::DATA_SIZE-1:0]  w_data,
  output logic [ntm_pkg::DATA_SIZE-1:0]  b_data
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Accumulators
  ////////////////////////////////////////////////////////////

  // dW(l,x), row l and column x
  logic [DATA_SIZE-1:0] w_acc [MAX_L][MAX_X];

  // db(l)
  logic [DATA_SIZE-1:0] b_acc [MAX_L];

  // Weight gradient
  // Whole column updated per product, all rows at once
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < MAX_L; l++) begin
        for (int x = 0; x < MAX_X; x++) begin
          w_acc[l][x] <= '0;
        end
      end
    end else if (clear) begin
      for (int l = 0; l < MAX_L; l++) begin
        for (int x = 0; x < MAX_X; x++) begin
          w_acc[l][x] <= '0;
        end
      end
    end else if (prod_valid) begin
      for (int l = 0; l < MAX_L; l++) begin
        w_acc[l][prod_index] <= w_acc[l][prod_index] + prod_column[l];
      end
    end
  end

  // Bias gradient
  // Sum of differences over time, telescopes to h(T-1)
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < MAX_L; l++) begin
        b_acc[l] <= '0;
      end
    end else if (clear) begin
      for (int l = 0; l < MAX_L; l++) begin
        b_acc[l] <= '0;
      end
    end else if (diff_valid) begin
      b_acc[diff_index] <= b_acc[diff_index] + diff_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////////////////////////

  // Plain muxes, the trainer registers the result
  assign w_data = w_acc[read_l][read_x];
  assign b_data = b_acc[read_l];

endmodule

// ==== logic/ntm_trainer.sv ====
////////////////////////////////////////////////////////////
// NTM trainer
// Streams h and x over T steps, returns dW row by row and db
////////////////////////////////////////////////////////////
module ntm_trainer (
  input  logic                           CLK,
  input  logic                           RST,

  // Run control
  input  logic                           START,
  output logic                           READY,

  // Input strobes, one per element
  input  logic                           H_IN_ENABLE,
  input  logic                           X_IN_ENABLE,

  // Output strobes
  output logic                           W_OUT_L_ENABLE,
  output logic                           W_OUT_X_ENABLE,
  output logic                           B_OUT_ENABLE,

  // Run sizes, sampled on START
  input  logic [ntm_pkg::COUNT_SIZE-1:0] SIZE_L_IN,
  input  logic [ntm_pkg::COUNT_SIZE-1:0] SIZE_X_IN,
  input  logic [ntm_pkg::STEP_SIZE-1:0]  SIZE_T_IN,

  // Data words
  input  logic [ntm_pkg::DATA_SIZE-1:0]  H_IN,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  X_IN,
  output logic [ntm_pkg::DATA_SIZE-1:0]  W_OUT,
  output logic [ntm_pkg::DATA_SIZE-1:0]  B_OUT
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // FSM
  logic [STATE_SIZE-1:0] state;

  // Sizes of the current run
  logic [COUNT_SIZE-1:0] size_l;
  logic [COUNT_SIZE-1:0] size_x;
  logic [STEP_SIZE-1:0]  size_t;

  // Last index of each loop
  logic [INDEX_SIZE-1:0] last_l;
  logic [INDEX_SIZE-1:0] last_x;
  logic [STEP_SIZE-1:0]  last_t;

  // Input phase counters
  logic [INDEX_SIZE-1:0] h_cnt;
  logic [INDEX_SIZE-1:0] x_cnt;
  logic [STEP_SIZE-1:0]  step_cnt;

  // All L h words of the step taken, x words expected
  logic                  h_done;

  // Gated strobes and run clear
  logic                  clear;
  logic                  h_valid;
  logic                  x_valid;

  // Differentiation to product and summation
  logic                  diff_valid;
  logic [INDEX_SIZE-1:0] diff_index;
  logic [DATA_SIZE-1:0]  diff_data;

  // Product to summation
  logic                  prod_valid;
  logic [INDEX_SIZE-1:0] prod_index;
  logic [DATA_SIZE-1:0]  prod_column [MAX_L];

  // Read-back
  logic [INDEX_SIZE-1:0] read_l;
  logic [INDEX_SIZE-1:0] read_x;
  logic [DATA_SIZE-1:0]  w_data;
  logic [DATA_SIZE-1:0]  b_data;

  ////////////////////////////////////////////////////////////
  // Strobe gating
  ////////////////////////////////////////////////////////////

  assign last_l = INDEX_SIZE'(size_l - 1'b1);
  assign last_x = INDEX_SIZE'(size_x - 1'b1);
  assign last_t = size_t - 1'b1;

  // START only counts in idle, and clears in the same cycle
  assign clear = (state == IDLE_STATE) && START;

  // h words first, then x words, anything else dropped
  assign h_valid = (state == INPUT_STATE) && H_IN_ENABLE && !h_done;
  assign x_valid = (state == INPUT_STATE) && X_IN_ENABLE && h_done;

  ////////////////////////////////////////////////////////////
  // Phase FSM and output sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= IDLE_STATE;
      size_l         <= '0;
      size_x         <= '0;
      size_t         <= '0;
      h_cnt          <= '0;
      x_cnt          <= '0;
      step_cnt       <= '0;
      h_done         <= 1'b0;
      read_l         <= '0;
      read_x         <= '0;
      READY          <= 1'b0;
      W_OUT_L_ENABLE <= 1'b0;
      W_OUT_X_ENABLE <= 1'b0;
      B_OUT_ENABLE   <= 1'b0;
      W_OUT          <= '0;
      B_OUT          <= '0;
    end else begin
      // Strobes and READY are single-cycle pulses
      W_OUT_L_ENABLE <= 1'b0;
      W_OUT_X_ENABLE <= 1'b0;
      B_OUT_ENABLE   <= 1'b0;
      READY          <= 1'b0;

      case (state)
        IDLE_STATE: begin
          if (START) begin
            size_l   <= SIZE_L_IN;
            size_x   <= SIZE_X_IN;
            size_t   <= SIZE_T_IN;
            h_cnt    <= '0;
            x_cnt    <= '0;
            step_cnt <= '0;
            h_done   <= 1'b0;
            read_l   <= '0;
            read_x   <= '0;
            state    <= INPUT_STATE;
          end
        end

        INPUT_STATE: begin
          // h and x strobes are exclusive by the h_done gate
          if (h_valid) begin
            if (h_cnt == last_l) begin
              h_cnt  <= '0;
              h_done <= 1'b1;
            end else begin
              h_cnt <= h_cnt + 1'b1;
            end
          end
          if (x_valid) begin
            if (x_cnt == last_x) begin
              // Step complete, next one starts with h words
              x_cnt  <= '0;
              h_done <= 1'b0;
              if (step_cnt == last_t) begin
                // Strobe edge fills the product register, stage 1
                state <= DRAIN_STATE;
              end else begin
                step_cnt <= step_cnt + 1'b1;
              end
            end else begin
              x_cnt <= x_cnt + 1'b1;
            end
          end
        end

        DRAIN_STATE: begin
          // Stage 2, last column lands in dW
          // Stage 3 is the output register during the W phase
          state <= W_STATE;
        end

        W_STATE: begin
          // Row-major, L strobe marks the start of each row
          W_OUT          <= w_data;
          W_OUT_X_ENABLE <= 1'b1;
          W_OUT_L_ENABLE <= (read_x == '0);
          if (read_x == last_x) begin
            read_x <= '0;
            if (read_l == last_l) begin
              read_l <= '0;
              state  <= B_STATE;
            end else begin
              read_l <= read_l + 1'b1;
            end
          end else begin
            read_x <= read_x + 1'b1;
          end
        end

        B_STATE: begin
          B_OUT        <= b_data;
          B_OUT_ENABLE <= 1'b1;
          if (read_l == last_l) begin
            state <= READY_STATE;
          end else begin
            read_l <= read_l + 1'b1;
          end
        end

        READY_STATE: begin
          // Lands the cycle after the last B word
          READY <= 1'b1;
          state <= IDLE_STATE;
        end

        default: begin
          state <= IDLE_STATE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Function blocks
  ////////////////////////////////////////////////////////////

  // d(t) = h(t) - h(t-1)
  ntm_vector_differentiation vector_differentiation (
    .CLK        (CLK),
    .RST        (RST),
    .clear      (clear),
    .h_valid    (h_valid),
    .h_index    (h_cnt),
    .h_data     (H_IN),
    .diff_valid (diff_valid),
    .diff_index (diff_index),
    .diff_data  (diff_data)
  );

  // d(t)·x(t), one column per x word
  ntm_matrix_product matrix_product (
    .CLK         (CLK),
    .RST         (RST),
    .diff_valid  (diff_valid),
    .diff_index  (diff_index),
    .diff_data   (diff_data),
    .x_valid     (x_valid),
    .x_index     (x_cnt),
    .x_data      (X_IN),
    .prod_valid  (prod_valid),
    .prod_index  (prod_index),
    .prod_column (prod_column)
  );

  // dW and db accumulators
  ntm_vector_summation vector_summation (
    .CLK         (CLK),
    .RST         (RST),
    .clear       (clear),
    .diff_valid  (diff_valid),
    .diff_index  (diff_index),
    .diff_data   (diff_data),
    .prod_valid  (prod_valid),
    .prod_index  (prod_index),
    .prod_column (prod_column),
    .read_l      (read_l),
    .read_x      (read_x),
    .w_data      (w_data),
    .b_data      (b_data)
  );

endmodule

// ==== testbench/ntm_trainer_tb.sv ====
////////////////////////////////////////////////////////////
// NTM trainer testbench
// Random h and x streams, reference dW and db, output checks
////////////////////////////////////////////////////////////
module ntm_trainer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ntm_pkg::*;

  localparam int MAX_T      = 8;
  localparam int CLK_PERIOD = 8;
  localparam logic [31:0] LFSR_SEED = 32'h5782;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // DUT ports
  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic                  H_IN_ENABLE;
  logic                  X_IN_ENABLE;
  logic [COUNT_SIZE-1:0] SIZE_L_IN;
  logic [COUNT_SIZE-1:0] SIZE_X_IN;
  logic [STEP_SIZE-1:0]  SIZE_T_IN;
  logic [DATA_SIZE-1:0]  H_IN;
  logic [DATA_SIZE-1:0]  X_IN;
  logic                  READY;
  logic                  W_OUT_L_ENABLE;
  logic                  W_OUT_X_ENABLE;
  logic                  B_OUT_ENABLE;
  logic [DATA_SIZE-1:0]  W_OUT;
  logic [DATA_SIZE-1:0]  B_OUT;

  // Stimulus and reference model
  logic [31:0]          lfsr_state;
  logic [DATA_SIZE-1:0] h_buf [MAX_T][MAX_L];
  logic [DATA_SIZE-1:0] x_buf [MAX_T][MAX_X];
  logic [DATA_SIZE-1:0] exp_w [MAX_L][MAX_X];
  logic [DATA_SIZE-1:0] exp_b [MAX_L];
  logic [DATA_SIZE-1:0] last_h [MAX_L];

  // Monitor state for the current run
  bit checking;
  int cur_l;
  int cur_x;
  int w_count;
  int b_count;
  int ready_count;
  int w_row;
  int w_col;

  // Report counters
  int errors;
  int tests_run;
  int tests_failed;
  int watchdog_ns;

  ntm_trainer dut (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .H_IN_ENABLE    (H_IN_ENABLE),
    .X_IN_ENABLE    (X_IN_ENABLE),
    .W_OUT_L_ENABLE (W_OUT_L_ENABLE),
    .W_OUT_X_ENABLE (W_OUT_X_ENABLE),
    .B_OUT_ENABLE   (B_OUT_ENABLE),
    .SIZE_L_IN      (SIZE_L_IN),
    .SIZE_X_IN      (SIZE_X_IN),
    .SIZE_T_IN      (SIZE_T_IN),
    .H_IN           (H_IN),
    .X_IN           (X_IN),
    .W_OUT          (W_OUT),
    .B_OUT          (B_OUT)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR, right shift, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  // Cycle budget of one run, words may take up to 4 cycles each
  function automatic int run_budget(input int l_len, input int x_len, input int t_len);
    return t_len * (l_len + x_len) * 4 + l_len * x_len + l_len + 200;
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_SIZE-1:0] expected,
                                 input logic [DATA_SIZE-1:0] actual);
    $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("[%0d] %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("[%0d] %s: fail, %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  // One element with a random idle gap in front
  task automatic send_word(input bit is_h, input logic [DATA_SIZE-1:0] data);
    repeat (take_bits(2)) @(negedge CLK);
    if (is_h) begin
      H_IN        = data;
      H_IN_ENABLE = 1'b1;
    end else begin
      X_IN        = data;
      X_IN_ENABLE = 1'b1;
    end
    @(negedge CLK);
    H_IN_ENABLE = 1'b0;
    X_IN_ENABLE = 1'b0;
  endtask

  // Strobes the DUT must drop, with junk data
  task automatic pulse_junk(input bit h_strobe, input bit x_strobe, input bit start);
    H_IN        = DATA_SIZE'(take_bits(16));
    X_IN        = DATA_SIZE'(take_bits(16));
    H_IN_ENABLE = h_strobe;
    X_IN_ENABLE = x_strobe;
    START       = start;
    @(negedge CLK);
    H_IN_ENABLE = 1'b0;
    X_IN_ENABLE = 1'b0;
    START       = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  // Outputs change on posedge, sampled half a cycle later
  always @(negedge CLK) begin
    if (checking) begin
      if (W_OUT_X_ENABLE) begin
        w_row = w_count / cur_x;
        w_col = w_count % cur_x;
        assert (w_count < cur_l * cur_x && b_count == 0)
          else report_error("W word after B words or beyond L*X words");
        if (w_count < cur_l * cur_x) begin
          assert (W_OUT == exp_w[w_row][w_col])
            else report_mismatch("W_OUT", exp_w[w_row][w_col], W_OUT);
          assert (W_OUT_L_ENABLE == (w_col == 0))
            else report_mismatch("W_OUT_L_ENABLE", 16'(w_col == 0), 16'(W_OUT_L_ENABLE));
        end
        w_count++;
      end else begin
        assert (!W_OUT_L_ENABLE) else report_error("W_OUT_L_ENABLE high without W_OUT_X_ENABLE");
      end
      if (B_OUT_ENABLE) begin
        assert (w_count == cur_l * cur_x && b_count < cur_l)
          else report_error("B word before all W words or beyond L words");
        if (b_count < cur_l) begin
          assert (B_OUT == exp_b[b_count]) else report_mismatch("B_OUT", exp_b[b_count], B_OUT);
          // Telescoped sum, independent of the model
          assert (B_OUT == last_h[b_count])
            else report_mismatch("B_OUT vs h(T-1)", last_h[b_count], B_OUT);
        end
        b_count++;
      end
      if (READY) begin
        assert (b_count == cur_l) else report_error("READY before all B words");
        ready_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Run sequence
  ////////////////////////////////////////////////////////////

  task automatic run_case(input string name, input int l_len, input int x_len,
                          input int t_len, input bit inject);
    int errs_before;
    int cyc;
    logic [DATA_SIZE-1:0] prev;
    logic [DATA_SIZE-1:0] d;
    errs_before = errors;

    // Fresh data and reference sums
    for (int t = 0; t < t_len; t++) begin
      for (int l = 0; l < l_len; l++) h_buf[t][l] = DATA_SIZE'(take_bits(16));
      for (int x = 0; x < x_len; x++) x_buf[t][x] = DATA_SIZE'(take_bits(16));
    end
    for (int l = 0; l < l_len; l++) begin
      exp_b[l] = '0;
      for (int x = 0; x < x_len; x++) exp_w[l][x] = '0;
      for (int t = 0; t < t_len; t++) begin
        prev = (t == 0) ? '0 : h_buf[t-1][l];
        d    = h_buf[t][l] - prev;
        exp_b[l] = exp_b[l] + d;
        for (int x = 0; x < x_len; x++) exp_w[l][x] = exp_w[l][x] + d * x_buf[t][x];
      end
      last_h[l] = h_buf[t_len-1][l];
    end

    cur_l       = l_len;
    cur_x       = x_len;
    w_count     = 0;
    b_count     = 0;
    ready_count = 0;
    checking    = 1'b1;
    SIZE_L_IN   = COUNT_SIZE'(l_len);
    SIZE_X_IN   = COUNT_SIZE'(x_len);
    SIZE_T_IN   = STEP_SIZE'(t_len);
    START       = 1'b1;
    @(negedge CLK);
    START = 1'b0;

    for (int t = 0; t < t_len; t++) begin
      for (int l = 0; l < l_len; l++) begin
        // Early X strobe and a stray START while h words are missing
        if (inject && t == 1 && l == l_len - 1) pulse_junk(1'b0, 1'b1, 1'b1);
        send_word(1'b1, h_buf[t][l]);
      end
      for (int x = 0; x < x_len; x++) begin
        // Extra h word once the step is in its x phase
        if (inject && t == 2 && x == 0) pulse_junk(1'b1, 1'b0, 1'b0);
        send_word(1'b0, x_buf[t][x]);
      end
    end

    // Wait for READY, junk strobes during drain when injecting
    cyc = 0;
    while (!READY && cyc < DRAIN_CYCLES + l_len * x_len + l_len + 20) begin
      H_IN_ENABLE = inject && (cyc < 4);
      X_IN_ENABLE = inject && (cyc < 4);
      @(negedge CLK);
      cyc++;
    end
    H_IN_ENABLE = 1'b0;
    X_IN_ENABLE = 1'b0;
    assert (READY) else report_error("READY did not arrive after the last x word");
    repeat (2) @(negedge CLK);
    checking = 1'b0;

    assert (w_count == l_len * x_len) else report_error("wrong number of W words");
    assert (b_count == l_len) else report_error("wrong number of B words");
    assert (ready_count == 1) else report_error("READY did not pulse exactly once");
    close_test(name, errs_before);
  endtask

  // Hang guard over the whole run
  initial begin
    watchdog_ns = CLK_PERIOD * (run_budget(4, 4, 5) + run_budget(3, 2, 3) + run_budget(2, 3, 4));
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the DUT appears to hang", watchdog_ns);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int errs_before;
    START       = 1'b0;
    H_IN_ENABLE = 1'b0;
    X_IN_ENABLE = 1'b0;
    SIZE_L_IN   = '0;
    SIZE_X_IN   = '0;
    SIZE_T_IN   = '0;
    H_IN        = '0;
    X_IN        = '0;
    checking    = 1'b0;
    errors      = 0;
    lfsr_state  = LFSR_SEED;
    RST         = 1'b1;
    repeat (5) @(negedge CLK);
    RST = 1'b0;

    // Idle outputs before any START
    errs_before = errors;
    repeat (4) begin
      @(negedge CLK);
      assert ({READY, W_OUT_L_ENABLE, W_OUT_X_ENABLE, B_OUT_ENABLE} == 4'b0)
        else report_error("READY or an output enable is high after reset");
      assert (W_OUT == '0) else report_mismatch("W_OUT", '0, W_OUT);
      assert (B_OUT == '0) else report_mismatch("B_OUT", '0, B_OUT);
    end
    close_test("reset state", errs_before);

    run_case("full size run L=4 X=4 T=5", 4, 4, 5, 1'b0);
    run_case("second run L=3 X=2 T=3", 3, 2, 3, 1'b0);
    run_case("stray strobes L=2 X=3 T=4", 2, 3, 4, 1'b1);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
logic/ntm_pkg.sv
logic/ntm_vector_differentiation.sv
logic/ntm_matrix_product.sv
logic/ntm_vector_summation.sv
logic/ntm_trainer.sv
testbench/ntm_trainer_tb.sv
